/* flist.f */
+incdir+source
source/simd_slice_pkg.sv
source/noncomp_lane.sv
source/lane_array.sv
source/sideband_pipe.sv
source/result_assembler.sv
source/simd_slice_top.sv
verification/simd_slice_tb.sv

/* verification/simd_slice_tb.sv */
`default_nettype none

// --------------------
// SIMD slice testbench
// Directed tests for sign injection, min/max, back-pressure,
// flush and latency against a reference model
// --------------------

`include "simd_slice_consts.svh"

module simd_slice_tb import simd_slice_pkg::*; ();

  localparam int unsigned SEED           = 32'hdf9eeb13;
  localparam int unsigned TIMEOUT_CYCLES = 50;
  localparam int unsigned DRIVE_DELAY    = 2;   // Input skew after the rising edge

  logic    clk;
  logic    rst_n;
  word_t   operands_a;
  word_t   operands_b;
  op_e     op;
  logic    op_mod;
  fmt_e    fmt;
  logic    vectorial_op;
  tag_t    tag_in;
  logic    in_valid;
  logic    in_ready;
  logic    flush;
  word_t   result;
  status_t status;
  tag_t    tag_out;
  logic    out_valid;
  logic    out_ready;
  logic    busy;

  int unsigned error_count   = 0;
  int unsigned timeout_count = 0;
  int unsigned check_count   = 0;
  tag_t        next_tag      = 8'h10;

  simd_slice_top dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .operands_a_i (operands_a), .operands_b_i (operands_b),
    .op_i (op), .op_mod_i (op_mod), .fmt_i (fmt), .vectorial_op_i (vectorial_op),
    .tag_i (tag_in), .in_valid_i (in_valid), .in_ready_o (in_ready), .flush_i (flush),
    .result_o (result), .status_o (status), .tag_o (tag_out),
    .out_valid_o (out_valid), .out_ready_i (out_ready), .busy_o (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic logic ref_is_nan(logic [31:0] v, int unsigned w);
    if (w == 32) return (v[30:23] == 8'hff) && (v[22:0] != 0);
    return (v[14:10] == 5'h1f) && (v[9:0] != 0);
  endfunction

  // Unsigned key that sorts like the FP value, -0 below +0
  function automatic logic [31:0] order_key(logic [31:0] v, int unsigned w);
    logic [31:0] mask;
    mask = (w == 32) ? 32'hffff_ffff : 32'h0000_ffff;
    if (v[w-1]) return ~v & mask;
    return (v & mask) | (32'h1 << (w - 1));
  endfunction

  task automatic ref_elem(input logic [31:0] a, input logic [31:0] b, input op_e op_sel,
                          input logic mod, input int unsigned w,
                          output logic [31:0] res, output logic nv);
    logic [31:0] mask;
    logic [31:0] sbit;
    logic [31:0] mag;
    logic        nan_a;
    logic        nan_b;
    logic        quiet_a;
    logic        quiet_b;
    mask    = (w == 32) ? 32'hffff_ffff : 32'h0000_ffff;
    sbit    = 32'h1 << (w - 1);
    mag     = a & mask & ~sbit;
    nan_a   = ref_is_nan(a, w);
    nan_b   = ref_is_nan(b, w);
    quiet_a = (w == 32) ? a[22] : a[9];
    quiet_b = (w == 32) ? b[22] : b[9];
    nv      = 1'b0;
    case (op_sel)
      OP_SGNJ:  res = mag | (b & sbit);
      OP_SGNJN: res = mag | (~b & sbit);
      OP_SGNJX: res = mag | ((a ^ b) & sbit);
      default: begin
        nv = (nan_a && !quiet_a) || (nan_b && !quiet_b);
        if (nan_a && nan_b) res = (w == 32) ? 32'(`FP32_QNAN) : 32'(`FP16_QNAN);
        else if (nan_a)     res = b & mask;
        else if (nan_b)     res = a & mask;
        else if (mod)       res = (order_key(a, w) > order_key(b, w)) ? (a & mask) : (b & mask);
        else                res = (order_key(a, w) < order_key(b, w)) ? (a & mask) : (b & mask);
      end
    endcase
  endtask

  task automatic model_word(input word_t a, input word_t b, input op_e op_sel, input logic mod,
                            input fmt_e f, input logic vec,
                            output word_t exp_word, output status_t exp_status);
    int unsigned w;
    int unsigned n;
    logic [31:0] res;
    logic        nv;
    w          = (f == FMT_FP32) ? 32 : 16;
    n          = vec ? (`SLICE_WIDTH / w) : 1;
    exp_word   = '1;                            // Boxed unless a lane fills the slot
    exp_status = '0;
    for (int unsigned i = 0; i < n; i++) begin
      ref_elem(32'(a >> (i * w)), 32'(b >> (i * w)), op_sel, mod, w, res, nv);
      for (int unsigned k = 0; k < w; k++) exp_word[i*w + k] = res[k];
      exp_status[STATUS_NV] = exp_status[STATUS_NV] | nv;
    end
  endtask

  // --------------------
  // Driver tasks
  // --------------------
  // Each task starts and ends a drive delay after a rising edge
  task automatic send_item(input word_t a, input word_t b, input op_e op_sel, input logic mod,
                           input fmt_e f, input logic vec, input tag_t t);
    int unsigned cycles;
    logic        accepted;
    @(posedge clk);
    #DRIVE_DELAY;
    operands_a   = a;
    operands_b   = b;
    op           = op_sel;
    op_mod       = mod;
    fmt          = f;
    vectorial_op = vec;
    tag_in       = t;
    in_valid     = 1'b1;
    cycles       = 0;
    accepted     = 1'b0;
    while (!accepted && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      accepted = in_ready;                      // Transfer at the coming edge
      @(posedge clk);
      cycles++;
    end
    #DRIVE_DELAY;
    in_valid = 1'b0;
    if (!accepted) begin
      $display("Timeout: in_ready_o stayed low for the item with tag %h", t);
      timeout_count++;
    end
  endtask

  task automatic receive_item(output word_t r, output status_t s, output tag_t t,
                              output logic got);
    int unsigned cycles;
    got       = 1'b0;
    cycles    = 0;
    r         = '0;
    s         = '0;
    t         = '0;
    out_ready = 1'b1;
    while (!got && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (out_valid) begin
        got = 1'b1;
        r   = result;
        s   = status;
        t   = tag_out;
      end
      @(posedge clk);
      cycles++;
    end
    #DRIVE_DELAY;
    if (!got) begin
      $display("Timeout: no result appeared on the output");
      timeout_count++;
    end
  endtask

  task automatic do_op(input word_t a, input word_t b, input op_e op_sel, input logic mod,
                       input fmt_e f, input logic vec);
    word_t   exp_word;
    status_t exp_status;
    word_t   got_word;
    status_t got_status;
    tag_t    got_tag;
    tag_t    sent_tag;
    logic    got;
    model_word(a, b, op_sel, mod, f, vec, exp_word, exp_status);
    sent_tag = next_tag;
    next_tag++;
    send_item(a, b, op_sel, mod, f, vec, sent_tag);
    receive_item(got_word, got_status, got_tag, got);
    if (got) begin
      check_word("result_o", got_word, exp_word);
      check_status("status_o", got_status, exp_status);
      check_tag("tag_o", got_tag, sent_tag);
    end
  endtask

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_reset_and_scalar();
    @(negedge clk);
    check_flag("in_ready_o", in_ready, 1'b1);
    check_flag("out_valid_o", out_valid, 1'b0);
    check_flag("busy_o", busy, 1'b0);
    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < 3; i++) begin
      do_op(rand_word(), rand_word(), op_e'(i), 1'b0, FMT_FP32, 1'b0);
      do_op(rand_word(), rand_word(), op_e'(i), 1'b0, FMT_FP16, 1'b0);
    end
  endtask

  task automatic test_vector_sgnj();
    for (int n = 0; n < 4; n++) begin
      for (int i = 0; i < 3; i++) begin
        do_op(rand_word(), rand_word(), op_e'(i), 1'b0, FMT_FP16, 1'b1);
        do_op(rand_word(), rand_word(), op_e'(i), 1'b0, FMT_FP32, 1'b1);
      end
    end
  endtask

  task automatic minmax_both(input word_t a, input word_t b, input fmt_e f, input logic vec);
    do_op(a, b, OP_MINMAX, 1'b0, f, vec);
    do_op(a, b, OP_MINMAX, 1'b1, f, vec);
  endtask

  task automatic test_minmax();
    minmax_both({32'h8000_0000, 32'h0000_0000}, {32'h0000_0000, 32'h8000_0000}, FMT_FP32, 1'b1);
    minmax_both(64'h8000_0000_8000_0000, 64'h0000_8000_0000_8000, FMT_FP16, 1'b1);
    minmax_both({32'h4000_0000, 32'h7fc0_0000}, {32'h7fc0_0001, 32'h3f80_0000}, FMT_FP32, 1'b1);
    minmax_both({32'h7fc0_0001, 32'hc120_0000}, {32'hffc0_0000, 32'hc110_0000}, FMT_FP32, 1'b1);
    minmax_both(64'h7e01_3c00_fe00_0000, 64'h7e00_7e00_7e10_8000, FMT_FP16, 1'b1);
    // Signaling NaNs, in lane 0 and in lane 3
    minmax_both({32'h3f80_0000, 32'h7f80_0001}, {32'h4000_0000, 32'h3f80_0000}, FMT_FP32, 1'b1);
    minmax_both(64'h7d00_3c00_4000_4400, 64'h3c00_4000_3c00_c400, FMT_FP16, 1'b1);
    // Inactive lane holds an sNaN, so no flag for a scalar
    minmax_both(64'h7d00_7d00_7d00_3c00, 64'h7d00_7d00_7d00_bc00, FMT_FP16, 1'b0);
  endtask

  task automatic test_backpressure();
    word_t   a [2];
    word_t   b [2];
    word_t   exp_word [2];
    status_t exp_status [2];
    tag_t    sent_tag [2];
    word_t   got_word;
    status_t got_status;
    tag_t    got_tag;
    logic    got;
    out_ready = 1'b0;
    for (int i = 0; i < 2; i++) begin
      a[i]        = rand_word();
      b[i]        = rand_word();
      sent_tag[i] = next_tag;
      next_tag++;
      model_word(a[i], b[i], op_e'(i), 1'b0, FMT_FP16, 1'b1, exp_word[i], exp_status[i]);
      send_item(a[i], b[i], op_e'(i), 1'b0, FMT_FP16, 1'b1, sent_tag[i]);
    end
    repeat (3) begin
      @(negedge clk);
      check_flag("in_ready_o", in_ready, 1'b0);   // Both stages full
      check_flag("out_valid_o", out_valid, 1'b1);
      check_flag("busy_o", busy, 1'b1);
      check_tag("tag_o", tag_out, sent_tag[0]);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < 2; i++) begin
      receive_item(got_word, got_status, got_tag, got);
      if (got) begin
        check_word("result_o", got_word, exp_word[i]);
        check_status("status_o", got_status, exp_status[i]);
        check_tag("tag_o", got_tag, sent_tag[i]);
      end
    end
  endtask

  task automatic test_flush();
    out_ready = 1'b0;
    send_item(rand_word(), rand_word(), OP_SGNJ, 1'b0, FMT_FP32, 1'b1, 8'hf0);
    send_item(rand_word(), rand_word(), OP_SGNJX, 1'b0, FMT_FP16, 1'b0, 8'hf1);
    flush = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    flush = 1'b0;
    @(negedge clk);
    check_flag("out_valid_o", out_valid, 1'b0);
    check_flag("busy_o", busy, 1'b0);
    check_flag("in_ready_o", in_ready, 1'b1);
    @(posedge clk);
    #DRIVE_DELAY;
    out_ready = 1'b1;
    do_op(rand_word(), rand_word(), OP_SGNJN, 1'b0, FMT_FP16, 1'b1);
  endtask

  // Counts rising edges from the accept edge to out_valid_o
  task automatic test_latency();
    word_t       a;
    word_t       b;
    word_t       exp_word;
    status_t     exp_status;
    int unsigned edges;
    logic        seen;
    a = rand_word();
    b = rand_word();
    model_word(a, b, OP_SGNJX, 1'b0, FMT_FP32, 1'b1, exp_word, exp_status);
    out_ready = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    operands_a   = a;
    operands_b   = b;
    op           = OP_SGNJX;
    op_mod       = 1'b0;
    fmt          = FMT_FP32;
    vectorial_op = 1'b1;
    tag_in       = 8'h5a;
    in_valid     = 1'b1;
    @(negedge clk);
    check_flag("in_ready_o", in_ready, 1'b1);
    @(posedge clk);
    edges = 1;
    seen  = 1'b0;
    #DRIVE_DELAY;
    in_valid = 1'b0;
    while (!seen && edges < TIMEOUT_CYCLES) begin
      @(negedge clk);
      seen = out_valid;
      if (seen) begin
        check_word("result_o", result, exp_word);
        check_status("status_o", status, exp_status);
        check_tag("tag_o", tag_out, 8'h5a);
      end
      @(posedge clk);
      if (!seen) edges++;
    end
    #DRIVE_DELAY;
    if (!seen) begin
      $display("Timeout: the latency item never reached the output");
      timeout_count++;
    end else if (edges != `SLICE_PIPE_REGS) begin
      $display("FAIL latency: got %h, expected %h", edges, `SLICE_PIPE_REGS);
      error_count++;
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(SEED));
    rst_n        = 1'b0;
    operands_a   = '0;
    operands_b   = '0;
    op           = OP_SGNJ;
    op_mod       = 1'b0;
    fmt          = FMT_FP32;
    vectorial_op = 1'b0;
    tag_in       = '0;
    in_valid     = 1'b0;
    flush        = 1'b0;
    out_ready    = 1'b1;
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    test_reset_and_scalar();
    test_vector_sgnj();
    test_minmax();
    test_backpressure();
    test_flush();
    test_latency();

    repeat (2) @(posedge clk);
    $display("Checks: %0d, value errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/simd_slice_top.sv */
`default_nettype none

// --------------------
// Packed-SIMD non-computational slice
// Lane array and sideband pipeline side by side, merged by the assembler
// --------------------

`include "simd_slice_consts.svh"

module simd_slice_top import simd_slice_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Operation
  input  word_t   operands_a_i,
  input  word_t   operands_b_i,
  input  op_e     op_i,
  input  logic    op_mod_i,
  input  fmt_e    fmt_i,
  input  logic    vectorial_op_i,
  input  tag_t    tag_i,
  // Input handshake
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  logic    flush_i,
  // Result
  output word_t   result_o,
  output status_t status_o,
  output tag_t    tag_o,
  // Output handshake
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output logic    busy_o
);

  lane_mask_t                 in_mask;      // Lanes holding the incoming item
  lane_mask_t                 out_mask;     // Lanes holding the item at the output
  elem_t   [`SLICE_LANES-1:0] lane_results;
  status_t [`SLICE_LANES-1:0] lane_status;
  fmt_e                       out_fmt;
  logic                       out_vector;

  lane_array u_lane_array (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .operands_a_i   ( operands_a_i   ),
    .operands_b_i   ( operands_b_i   ),
    .op_i           ( op_i           ),
    .op_mod_i       ( op_mod_i       ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .out_mask_i     ( out_mask       ),
    .out_ready_i    ( out_ready_i    ),
    .lane_mask_o    ( in_mask        ),
    .lane_results_o ( lane_results   ),
    .lane_status_o  ( lane_status    ),
    .out_valid_o    ( out_valid_o    ),
    .busy_o         ( busy_o         )
  );

  // Fed like lane 0, so both accept and advance together
  sideband_pipe u_sideband (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .tag_i          ( tag_i          ),
    .lane_mask_i    ( in_mask        ),
    .in_valid_i     ( in_valid_i     ),
    .flush_i        ( flush_i        ),
    .out_ready_i    ( out_ready_i    ),
    .out_fmt_o      ( out_fmt        ),
    .out_vector_o   ( out_vector     ),
    .out_mask_o     ( out_mask       ),
    .tag_o          ( tag_o          )
  );

  result_assembler u_assembler (
    .lane_results_i ( lane_results   ),
    .lane_status_i  ( lane_status    ),
    .out_fmt_i      ( out_fmt        ),
    .out_vector_i   ( out_vector     ),
    .out_mask_i     ( out_mask       ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       )
  );

endmodule

`default_nettype wire

/* source/result_assembler.sv */
`default_nettype none

// --------------------
// Result assembler
// Packs lane results into the output word with NaN-boxing
// and merges the lane status flags
// --------------------

`include "simd_slice_consts.svh"

module result_assembler import simd_slice_pkg::*; (
  input  elem_t   [`SLICE_LANES-1:0] lane_results_i,
  input  status_t [`SLICE_LANES-1:0] lane_status_i,
  input  fmt_e                       out_fmt_i,
  input  logic                       out_vector_i,
  input  lane_mask_t                 out_mask_i,
  output word_t                      result_o,
  output status_t                    status_o
);

  localparam int unsigned FP32_SLOTS = `SLICE_WIDTH / `FP32_WIDTH;
  localparam int unsigned FP16_SLOTS = `SLICE_WIDTH / `FP16_WIDTH;

  // --------------------
  // Result packing
  // --------------------
  always_comb begin
    result_o = '1;                      // Unused upper bits stay NaN-boxed
    if (out_fmt_i == FMT_FP16) begin
      if (out_vector_i) begin
        for (int unsigned l = 0; l < FP16_SLOTS; l++) begin
          result_o[l*`FP16_WIDTH +: `FP16_WIDTH] = lane_results_i[l][`FP16_WIDTH-1:0];
        end
      end else begin
        result_o[`FP16_WIDTH-1:0] = lane_results_i[0][`FP16_WIDTH-1:0];
      end
    end else begin
      if (out_vector_i) begin
        for (int unsigned l = 0; l < FP32_SLOTS; l++) begin
          result_o[l*`FP32_WIDTH +: `FP32_WIDTH] = lane_results_i[l];
        end
      end else begin
        result_o[`FP32_WIDTH-1:0] = lane_results_i[0];
      end
    end
  end

  // --------------------
  // Status collapse
  // --------------------
  // Only lanes that held the item contribute
  always_comb begin
    status_t acc;
    acc = '0;
    for (int unsigned l = 0; l < `SLICE_LANES; l++) begin
      if (out_mask_i[l]) begin
        acc |= lane_status_i[l];
      end
    end
    status_o = acc;
  end

endmodule

`default_nettype wire

/* source/sideband_pipe.sv */
`default_nettype none

// --------------------
// Sideband pipeline
// Carries format, vector flag, lane mask and tag in lockstep with lane 0
// --------------------

`include "simd_slice_consts.svh"

module sideband_pipe import simd_slice_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  fmt_e       fmt_i,
  input  logic       vectorial_op_i,
  input  tag_t       tag_i,
  input  lane_mask_t lane_mask_i,
  input  logic       in_valid_i,
  input  logic       flush_i,
  input  logic       out_ready_i,
  output fmt_e       out_fmt_o,
  output logic       out_vector_o,
  output lane_mask_t out_mask_o,
  output tag_t       tag_o
);

  localparam int unsigned SB_W = $bits(fmt_e) + 1 + $bits(lane_mask_t) + $bits(tag_t);

  logic [0:`SLICE_PIPE_REGS]           sb_valid_q;
  logic [0:`SLICE_PIPE_REGS]           sb_ready;
  logic [0:`SLICE_PIPE_REGS][SB_W-1:0] sb_data_q;
  logic                                out_fmt_bit;

  assign sb_valid_q[0] = in_valid_i;
  assign sb_data_q[0]  = {fmt_i, vectorial_op_i, lane_mask_i, tag_i};

  // Same advance rule as the lanes
  for (genvar i = 0; i < `SLICE_PIPE_REGS; i++) begin : gen_stages
    assign sb_ready[i] = sb_ready[i+1] | ~sb_valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        sb_valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        sb_valid_q[i+1] <= 1'b0;
      end else if (sb_ready[i]) begin
        sb_valid_q[i+1] <= sb_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (sb_ready[i] && sb_valid_q[i]) begin
        sb_data_q[i+1] <= sb_data_q[i];
      end
    end
  end

  assign sb_ready[`SLICE_PIPE_REGS] = out_ready_i;

  // --------------------
  // Output decode
  // --------------------
  assign {out_fmt_bit, out_vector_o, out_mask_o, tag_o} = sb_data_q[`SLICE_PIPE_REGS];
  assign out_fmt_o = fmt_e'(out_fmt_bit);

endmodule

`default_nettype wire

/* source/lane_array.sv */
`default_nettype none

// --------------------
// Lane array
// Slices the operand words into elements and runs each active lane
// through its own non-computational unit
// --------------------

`include "simd_slice_consts.svh"

module lane_array import simd_slice_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  word_t                         operands_a_i,
  input  word_t                         operands_b_i,
  input  op_e                           op_i,
  input  logic                          op_mod_i,
  input  fmt_e                          fmt_i,
  input  logic                          vectorial_op_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          flush_i,
  input  lane_mask_t                    out_mask_i,
  input  logic                          out_ready_i,
  output lane_mask_t                    lane_mask_o,
  output elem_t   [`SLICE_LANES-1:0]    lane_results_o,
  output status_t [`SLICE_LANES-1:0]    lane_status_o,
  output logic                          out_valid_o,
  output logic                          busy_o
);

  int unsigned            elem_w;         // Element width of the input format
  logic [`SLICE_LANES-1:0] lane_in_ready;
  logic [`SLICE_LANES-1:0] lane_out_valid;
  logic [`SLICE_LANES-1:0] lane_busy;

  assign elem_w = (fmt_i == FMT_FP32) ? `FP32_WIDTH : `FP16_WIDTH;

  // --------------------
  // Input lane mask
  // --------------------
  // Lane 0 always, upper lanes only if the element fits in the word
  always_comb begin
    for (int unsigned l = 0; l < `SLICE_LANES; l++) begin
      lane_mask_o[l] = (l == 0) || (vectorial_op_i && (l * elem_w < `SLICE_WIDTH));
    end
  end

  // --------------------
  // Lanes
  // --------------------
  for (genvar l = 0; l < `SLICE_LANES; l++) begin : gen_lanes
    // Lanes past the FP32 slots only ever see FP16
    localparam int unsigned LW =
        (l < `SLICE_WIDTH / `FP32_WIDTH) ? `FP32_WIDTH : `FP16_WIDTH;

    word_t shifted_a;
    word_t shifted_b;
    logic  lane_valid;
    logic  lane_ready;

    // Upper bits beyond the element are ignored inside the lane
    assign shifted_a  = operands_a_i >> (l * elem_w);
    assign shifted_b  = operands_b_i >> (l * elem_w);
    assign lane_valid = in_valid_i & lane_mask_o[l];
    assign lane_ready = out_ready_i & out_mask_i[l];   // Mask of the item at the output

    noncomp_lane #(
      .LANE_WIDTH ( LW )
    ) u_lane (
      .clk_i       ( clk_i                          ),
      .rst_n_i     ( rst_n_i                        ),
      .a_i         ( shifted_a[`FP32_WIDTH-1:0]     ),
      .b_i         ( shifted_b[`FP32_WIDTH-1:0]     ),
      .op_i        ( op_i                           ),
      .op_mod_i    ( op_mod_i                       ),
      .fmt_i       ( fmt_i                          ),
      .in_valid_i  ( lane_valid                     ),
      .in_ready_o  ( lane_in_ready[l]               ),
      .flush_i     ( flush_i                        ),
      .result_o    ( lane_results_o[l]              ),
      .status_o    ( lane_status_o[l]               ),
      .out_valid_o ( lane_out_valid[l]              ),
      .out_ready_i ( lane_ready                     ),
      .busy_o      ( lane_busy[l]                   )
    );
  end

  // Lane 0 carries every item, so it speaks for the array
  assign in_ready_o  = lane_in_ready[0];
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

`default_nettype wire

/* source/noncomp_lane.sv */
`default_nettype none

// --------------------
// Non-computational FP lane
// Sign injection and min/max on one FP32 or FP16 element,
// followed by a valid/ready register pipeline
// --------------------

`include "simd_slice_consts.svh"

module noncomp_lane import simd_slice_pkg::*; #(
  parameter int unsigned LANE_WIDTH = 32
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  elem_t   a_i,
  input  elem_t   b_i,
  input  op_e     op_i,
  input  logic    op_mod_i,
  input  fmt_e    fmt_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  logic    flush_i,
  output elem_t   result_o,
  output status_t status_o,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output logic    busy_o
);

  localparam int unsigned PAD = `FP32_WIDTH - `FP16_WIDTH;

  logic              is_fp32;
  logic              sign_a, sign_b, sign_res;
  logic [PAD+14:0]   mag_a, mag_b;    // Magnitude without sign, zero-extended for FP16
  logic              nan_a, nan_b;
  logic              snan_a, snan_b;
  logic              a_lt_b;
  elem_t             qnan;
  elem_t             op_result;
  status_t           op_status;

  // NaN: exponent all ones with a nonzero mantissa
  function automatic logic is_nan(elem_t v, logic fp32);
    if (fp32) begin
      return (&v[30:23]) && (|v[22:0]);
    end
    return (&v[14:10]) && (|v[9:0]);
  endfunction

  // Signaling when the mantissa MSB is clear
  function automatic logic is_snan(elem_t v, logic fp32);
    logic quiet_bit;
    quiet_bit = fp32 ? v[22] : v[9];
    return is_nan(v, fp32) && !quiet_bit;
  endfunction

  // --------------------
  // Operand decode
  // --------------------
  assign is_fp32 = (LANE_WIDTH == `FP32_WIDTH) && (fmt_i == FMT_FP32);

  assign sign_a = is_fp32 ? a_i[31] : a_i[15];
  assign sign_b = is_fp32 ? b_i[31] : b_i[15];
  assign mag_a  = is_fp32 ? a_i[30:0] : {{PAD{1'b0}}, a_i[14:0]};
  assign mag_b  = is_fp32 ? b_i[30:0] : {{PAD{1'b0}}, b_i[14:0]};

  assign nan_a  = is_nan(a_i, is_fp32);
  assign nan_b  = is_nan(b_i, is_fp32);
  assign snan_a = is_snan(a_i, is_fp32);
  assign snan_b = is_snan(b_i, is_fp32);

  assign qnan = is_fp32 ? `FP32_QNAN : {{PAD{1'b1}}, `FP16_QNAN};

  // Signed order, -0 below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a :
                  sign_a             ? (mag_a > mag_b) : (mag_a < mag_b);

  // --------------------
  // Operation
  // --------------------
  always_comb begin
    op_status = '0;
    case (op_i)
      OP_SGNJ:  sign_res = sign_b;
      OP_SGNJN: sign_res = ~sign_b;
      OP_SGNJX: sign_res = sign_a ^ sign_b;
      default:  sign_res = sign_a;
    endcase

    if (op_i == OP_MINMAX) begin
      if (nan_a && nan_b) begin
        op_result = qnan;
      end else if (nan_a) begin
        op_result = b_i;
      end else if (nan_b) begin
        op_result = a_i;
      end else begin
        op_result = (a_lt_b ^ op_mod_i) ? a_i : b_i; // op_mod_i picks the larger one
      end
      op_status[STATUS_NV] = snan_a | snan_b;
    end else if (is_fp32) begin
      op_result = {sign_res, a_i[30:0]};
    end else begin
      op_result = {{PAD{1'b1}}, sign_res, a_i[14:0]};
    end
  end

  // --------------------
  // Pipeline
  // --------------------
  // Index i holds the item after i register stages
  logic    [0:`SLICE_PIPE_REGS] pipe_valid_q;
  logic    [0:`SLICE_PIPE_REGS] pipe_ready;
  elem_t   [0:`SLICE_PIPE_REGS] pipe_result_q;
  status_t [0:`SLICE_PIPE_REGS] pipe_status_q;

  assign pipe_valid_q[0]  = in_valid_i;
  assign pipe_result_q[0] = op_result;
  assign pipe_status_q[0] = op_status;

  for (genvar i = 0; i < `SLICE_PIPE_REGS; i++) begin : gen_stages
    // Advance when the next stage moves on or holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (pipe_ready[i] && pipe_valid_q[i]) begin
        pipe_result_q[i+1] <= pipe_result_q[i];
        pipe_status_q[i+1] <= pipe_status_q[i];
      end
    end
  end

  assign pipe_ready[`SLICE_PIPE_REGS] = out_ready_i;

  assign in_ready_o  = pipe_ready[0];
  assign out_valid_o = pipe_valid_q[`SLICE_PIPE_REGS];
  assign result_o    = pipe_result_q[`SLICE_PIPE_REGS];
  assign status_o    = pipe_status_q[`SLICE_PIPE_REGS];
  assign busy_o      = |pipe_valid_q[1:`SLICE_PIPE_REGS];

endmodule

`default_nettype wire

/* source/simd_slice_pkg.sv */
`default_nettype none

// --------------------
// SIMD slice package
// Vector typedefs and enums shared by the slice and its testbench
// --------------------

`include "simd_slice_consts.svh"

package simd_slice_pkg;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [`SLICE_WIDTH-1:0] word_t;      // Operand or result word
  typedef logic [`FP32_WIDTH-1:0]  elem_t;      // One lane element
  typedef logic [`SLICE_LANES-1:0] lane_mask_t; // One bit per lane
  typedef logic [4:0]              status_t;    // NV, DZ, OF, UF, NX
  typedef logic [7:0]              tag_t;

  // Position of the invalid-operation flag in status_t
  localparam int unsigned STATUS_NV = 4;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic {
    FMT_FP32,
    FMT_FP16
  } fmt_e;

  typedef enum logic [1:0] {
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MINMAX   // op_mod_i selects max
  } op_e;

endpackage

`default_nettype wire

/* source/simd_slice_consts.svh */
// --------------------
// SIMD slice constants
// Datapath width, lane count, FP widths, pipeline depth and canonical NaNs
// --------------------

`ifndef SIMD_SLICE_CONSTS_SVH
`define SIMD_SLICE_CONSTS_SVH

// Datapath
`define SLICE_WIDTH      64
`define SLICE_LANES      4

// Floating-point formats
`define FP32_WIDTH       32
`define FP16_WIDTH       16

// Register stages per lane and in the sideband pipeline
`define SLICE_PIPE_REGS  2

// Canonical quiet NaNs
`define FP32_QNAN        32'h7fc0_0000
`define FP16_QNAN        16'h7e00

`endif
